// File: filelist.f
+incdir+verif
design/rv_isa_pkg.sv
design/ex_pkg.sv
design/int_alu.sv
design/divider.sv
design/ex_issue_ctrl.sv
design/int_ex_unit.sv
verif/int_ex_unit_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module int_ex_unit_tb \
	-Mdir obj_dir \
	-o sim_int_ex_unit

./obj_dir/sim_int_ex_unit

// File: verif/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Expected result of one execute operation
function automatic logic [rv_isa_pkg::xlen-1:0] ref_exec(
	input logic [rv_isa_pkg::alu_func_w-1:0] func,
	input logic [rv_isa_pkg::xlen-1:0]       a,
	input logic [rv_isa_pkg::xlen-1:0]       b
);
	logic [rv_isa_pkg::xlen-1:0]        res;
	logic                               ovf;
	logic signed [rv_isa_pkg::xlen-1:0] sa;
	logic signed [rv_isa_pkg::xlen-1:0] sb;
	logic signed [rv_isa_pkg::xlen-1:0] sq;
	logic signed [rv_isa_pkg::xlen-1:0] sr;
	sa  = a;
	sb  = b;
	ovf = (a == {1'b1, {(rv_isa_pkg::xlen-1){1'b0}}}) && (b == '1);
	// Language division truncates toward zero, remainder keeps the dividend sign
	if ((b != '0) && !ovf) begin
		sq = sa / sb;
		sr = sa % sb;
	end else begin
		sq = '0;
		sr = '0;
	end
	case (func)
		rv_isa_pkg::alu_add:  res = a + b;
		rv_isa_pkg::alu_sub:  res = a - b;
		rv_isa_pkg::alu_and:  res = a & b;
		rv_isa_pkg::alu_or:   res = a | b;
		rv_isa_pkg::alu_xor:  res = a ^ b;
		rv_isa_pkg::alu_sll:  res = a << b[4:0];
		rv_isa_pkg::alu_srl:  res = a >> b[4:0];
		rv_isa_pkg::alu_sra:  res = $signed(a) >>> b[4:0];
		rv_isa_pkg::alu_slt:  res = ($signed(a) < $signed(b)) ? 1 : 0;
		rv_isa_pkg::alu_sltu: res = (a < b) ? 1 : 0;
		// Division follows the RISC-V rules for zero divisor and overflow
		rv_isa_pkg::alu_div:  res = (b == '0) ? '1 : (ovf ? a : sq);
		rv_isa_pkg::alu_rem:  res = (b == '0) ? a : (ovf ? '0 : sr);
		rv_isa_pkg::alu_divu: res = (b == '0) ? '1 : a / b;
		rv_isa_pkg::alu_remu: res = (b == '0) ? a : a % b;
		default:              res = '0;
	endcase
	return res;
endfunction

`endif

// File: verif/int_ex_unit_tb.sv
`timescale 1ns/1ps

module int_ex_unit_tb;
	import rv_isa_pkg::*;
	import ex_pkg::*;

	`include "ex_ref_model.svh"

	logic                  clk;
	logic                  rst;
	logic                  issue_valid;
	logic [alu_func_w-1:0] issue_func;
	logic [xlen-1:0]       issue_opa;
	logic [xlen-1:0]       issue_opb;
	logic [tag_w-1:0]      issue_tag;
	logic                  ex_busy;
	logic                  result_valid;
	logic [xlen-1:0]       result_data;
	logic [tag_w-1:0]      result_tag;
	integer                seed;
	logic [tag_w-1:0]      next_tag;

	int_ex_unit dut_i (
		.clk          (clk),
		.rst          (rst),
		.issue_valid  (issue_valid),
		.issue_func   (issue_func),
		.issue_opa    (issue_opa),
		.issue_opb    (issue_opb),
		.issue_tag    (issue_tag),
		.ex_busy      (ex_busy),
		.result_valid (result_valid),
		.result_data  (result_data),
		.result_tag   (result_tag)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [xlen-1:0] exp,
		input logic [xlen-1:0] act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %h got %h", $time, what, exp, act);
			$display("Some tests failed");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	// Latency 0 means any latency is accepted
	task automatic run_op(input logic [alu_func_w-1:0] func, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b, input int exp_lat);
		int               cycles;
		logic [tag_w-1:0] tag;
		tag = next_tag;
		next_tag = next_tag + 1'b1;
		@(negedge clk);
		issue_valid = 1'b1;
		issue_func  = func;
		issue_opa   = a;
		issue_opb   = b;
		issue_tag   = tag;
		@(negedge clk);
		issue_valid = 1'b0;
		cycles = 0;
		while (!result_valid) begin
			check_value("ex_busy while pending", 1, ex_busy);
			@(negedge clk);
			cycles++;
			if (cycles > 100) begin
				$display("Some tests failed");
				$fatal(1, "Timed out waiting for result_valid");
			end
		end
		check_value("result_data", ref_exec(func, a, b), result_data);
		check_value("result_tag", {{(xlen-tag_w){1'b0}}, tag}, {{(xlen-tag_w){1'b0}}, result_tag});
		check_value("ex_busy after result", 0, ex_busy);
		if (exp_lat != 0) begin
			check_value("latency", exp_lat, cycles);
		end
	endtask

	task automatic test_alu;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		// ALU codes run from add up to sltu
		for (int f = 0; f <= int'(alu_sltu); f++) begin
			run_op(f[alu_func_w-1:0], 32'h8000_00f3, 32'h0000_0024, 1);
			a = $random(seed);
			b = $random(seed);
			run_op(f[alu_func_w-1:0], a, b, 1);
			run_op(f[alu_func_w-1:0], b, a, 1);
		end
	endtask

	task automatic test_unsigned_div;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		run_op(alu_divu, 100, 7, 0);
		run_op(alu_remu, 32'hffff_ffff, 3, 0);
		run_op(alu_divu, 32'h8000_0000, 32'h10, 0);
		run_op(alu_remu, 5, 9, 0);
		run_op(alu_divu, 32'hdead_beef, 32'h0001_2345, 0);
		for (int i = 0; i < 16; i++) begin
			a = $random(seed);
			b = $random(seed);
			b = b >> b[4:0];
			if (i % 2 == 0) begin
				a[xlen-1] = 1'b1;
			end
			run_op(alu_divu, a, b, 0);
			run_op(alu_remu, a, b, 0);
		end
	endtask

	task automatic test_signed_div;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		for (int s = 0; s < 4; s++) begin
			a = s[0] ? -32'd1000003 : 32'd1000003;
			b = s[1] ? -32'd97 : 32'd97;
			run_op(alu_div, a, b, 0);
			run_op(alu_rem, a, b, 0);
		end
		for (int i = 0; i < 8; i++) begin
			a = $random(seed);
			b = $random(seed);
			b = $signed(b) >>> b[4:0];
			run_op(alu_div, a, b, 0);
			run_op(alu_rem, a, b, 0);
		end
	endtask

	task automatic test_edge_cases;
		for (int f = int'(alu_div); f <= int'(alu_remu); f++) begin
			run_op(f[alu_func_w-1:0], 32'h1234_5678, 0, 1);
		end
		run_op(alu_div, 32'h8000_0000, 32'hffff_ffff, 1);
		run_op(alu_rem, 32'h8000_0000, 32'hffff_ffff, 1);
	endtask

	task automatic test_mixed;
		run_op(alu_div, -1000, 7, 0);
		run_op(alu_add, 5, 6, 1);
		run_op(alu_div, -1000, 7, 0);
		// Same operands again, so the divider is already done
		run_op(alu_rem, -1000, 7, 1);
	endtask

	initial begin
		seed        = 32'hf46f;
		next_tag    = '0;
		rst         = 1'b1;
		issue_valid = 1'b0;
		issue_func  = alu_add;
		issue_opa   = '0;
		issue_opb   = '0;
		issue_tag   = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		check_value("ex_busy after reset", 0, ex_busy);
		check_value("result_valid after reset", 0, result_valid);
		test_alu();
		test_unsigned_div();
		test_signed_div();
		test_edge_cases();
		test_mixed();
		$display("All tests passed");
		$finish;
	end

endmodule

// File: design/int_ex_unit.sv
`timescale 1ns/1ps

module int_ex_unit (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              issue_valid,
	input  logic [rv_isa_pkg::alu_func_w-1:0] issue_func,
	input  logic [rv_isa_pkg::xlen-1:0]       issue_opa,
	input  logic [rv_isa_pkg::xlen-1:0]       issue_opb,
	input  logic [ex_pkg::tag_w-1:0]          issue_tag,
	output logic                              ex_busy,
	output logic                              result_valid,
	output logic [rv_isa_pkg::xlen-1:0]       result_data,
	output logic [ex_pkg::tag_w-1:0]          result_tag
);
	import rv_isa_pkg::*;

	logic [alu_func_w-1:0] op_func;
	logic [xlen-1:0]       op_a;
	logic [xlen-1:0]       op_b;
	logic [xlen-1:0]       alu_result;
	logic [xlen-1:0]       quotient;
	logic [xlen-1:0]       remainder;
	logic                  div_busy;
	logic                  div_sel;

	ex_issue_ctrl ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.issue_valid  (issue_valid),
		.issue_func   (issue_func),
		.issue_opa    (issue_opa),
		.issue_opb    (issue_opb),
		.issue_tag    (issue_tag),
		.alu_result   (alu_result),
		.quotient     (quotient),
		.remainder    (remainder),
		.div_sel      (div_sel),
		.div_busy     (div_busy),
		.op_func      (op_func),
		.op_a         (op_a),
		.op_b         (op_b),
		.ex_busy      (ex_busy),
		.result_valid (result_valid),
		.result_data  (result_data),
		.result_tag   (result_tag)
	);

	int_alu alu_i (
		.func   (op_func),
		.opa    (op_a),
		.opb    (op_b),
		.result (alu_result)
	);

	divider div_i (
		.clk       (clk),
		.rst       (rst),
		.opa       (op_a),
		.opb       (op_b),
		.func      (op_func),
		.quotient  (quotient),
		.remainder (remainder),
		.busy      (div_busy),
		.div_sel   (div_sel)
	);

endmodule

// File: design/ex_issue_ctrl.sv
`timescale 1ns/1ps

module ex_issue_ctrl (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              issue_valid,
	input  logic [rv_isa_pkg::alu_func_w-1:0] issue_func,
	input  logic [rv_isa_pkg::xlen-1:0]       issue_opa,
	input  logic [rv_isa_pkg::xlen-1:0]       issue_opb,
	input  logic [ex_pkg::tag_w-1:0]          issue_tag,
	input  logic [rv_isa_pkg::xlen-1:0]       alu_result,
	input  logic [rv_isa_pkg::xlen-1:0]       quotient,
	input  logic [rv_isa_pkg::xlen-1:0]       remainder,
	input  logic                              div_sel,
	input  logic                              div_busy,
	output logic [rv_isa_pkg::alu_func_w-1:0] op_func,
	output logic [rv_isa_pkg::xlen-1:0]       op_a,
	output logic [rv_isa_pkg::xlen-1:0]       op_b,
	output logic                              ex_busy,
	output logic                              result_valid,
	output logic [rv_isa_pkg::xlen-1:0]       result_data,
	output logic [ex_pkg::tag_w-1:0]          result_tag
);
	import rv_isa_pkg::*;
	import ex_pkg::*;

	logic             state;
	logic [tag_w-1:0] op_tag;
	logic             op_done;
	logic [xlen-1:0]  op_result;

	assign ex_busy = (state == st_pend);

	// ALU ops finish in their first pending cycle, divides wait for the divider
	assign op_done = (state == st_pend) && !(div_sel && div_busy);

	// Bit 0 of a division code selects the remainder
	assign op_result = div_sel ? (op_func[0] ? remainder : quotient) : alu_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= st_idle;
			op_func      <= '0;
			op_a         <= '0;
			op_b         <= '0;
			result_valid <= 1'b0;
			result_data  <= result_rst;
		end else begin
			result_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (issue_valid) begin
						op_func <= issue_func;
						op_a    <= issue_opa;
						op_b    <= issue_opb;
						state   <= st_pend;
					end
				end
				st_pend: begin
					if (op_done) begin
						result_valid <= 1'b1;
						result_data  <= op_result;
						state        <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Tag rides alongside the operation
	always_ff @(posedge clk) begin
		if ((state == st_idle) && issue_valid) begin
			op_tag <= issue_tag;
		end
		if (op_done) begin
			result_tag <= op_tag;
		end
	end

	a_no_issue_when_busy: assert property (
		@(posedge clk) disable iff (rst)
		!(issue_valid && ex_busy)
	);

	a_single_result_pulse: assert property (
		@(posedge clk) disable iff (rst)
		result_valid |=> !result_valid
	);

endmodule

// File: design/divider.sv
`timescale 1ns/1ps

module divider (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [rv_isa_pkg::xlen-1:0]       opa,
	input  logic [rv_isa_pkg::xlen-1:0]       opb,
	input  logic [rv_isa_pkg::alu_func_w-1:0] func,
	output logic [rv_isa_pkg::xlen-1:0]       quotient,
	output logic [rv_isa_pkg::xlen-1:0]       remainder,
	output logic                              busy,
	output logic                              div_sel
);
	import rv_isa_pkg::*;

	logic            signed_op;
	logic [xlen-1:0] n_mag;
	logic [xlen-1:0] d_mag;
	logic [xlen-1:0] n_prev;
	logic [xlen-1:0] d_prev;
	logic            new_input;
	logic [4:0]      n_msb;
	logic [4:0]      d_msb;
	logic [xlen-1:0] q_mag;
	logic [xlen-1:0] r_mag;
	logic [xlen-1:0] sub;
	logic [5:0]      cnt;
	logic            done;
	logic            ec_flag;
	logic [xlen-1:0] q_ec;
	logic [xlen-1:0] r_ec;
	logic            q_neg;
	logic            r_neg;

	assign signed_op = (func == alu_div) || (func == alu_rem);
	assign div_sel   = signed_op || (func == alu_divu) || (func == alu_remu);

	// Work on magnitudes, signs go back on at the outputs
	assign n_mag = (signed_op && opa[xlen-1]) ? -opa : opa;
	assign d_mag = (signed_op && opb[xlen-1]) ? -opb : opb;

	// Any change of the magnitudes restarts the iteration
	assign new_input = (n_mag != n_prev) || (d_mag != d_prev);

	always_comb begin
		n_msb = '0;
		d_msb = '0;
		for (int i = 0; i < xlen; i++) begin
			if (n_mag[i]) begin
				n_msb = 5'(i);
			end
			if (d_mag[i]) begin
				d_msb = 5'(i);
			end
		end
	end

	// Zero divisor and signed overflow bypass the iteration
	always_comb begin
		if (opb == '0) begin
			q_ec    = '1;
			r_ec    = opa;
			ec_flag = 1'b1;
		end else if (signed_op && (opa == {1'b1, {(xlen-1){1'b0}}}) && (opb == '1)) begin
			q_ec    = opa;
			r_ec    = '0;
			ec_flag = 1'b1;
		end else begin
			q_ec    = '0;
			r_ec    = '0;
			ec_flag = 1'b0;
		end
	end

	assign done = (cnt == '0) && !new_input;

	always_ff @(posedge clk) begin
		if (rst) begin
			n_prev <= '0;
			d_prev <= '0;
			cnt    <= '0;
		end else if (new_input) begin
			n_prev <= n_mag;
			d_prev <= d_mag;
			// One step per quotient bit from d_msb up to n_msb
			if (n_msb >= d_msb) begin
				cnt <= {1'b0, n_msb} - {1'b0, d_msb} + 6'd1;
			end else begin
				cnt <= '0;
			end
		end else if (!done) begin
			cnt <= cnt - 6'd1;
		end
	end

	// Partial remainder and aligned subtrahend
	always_ff @(posedge clk) begin
		if (new_input) begin
			q_mag <= '0;
			r_mag <= n_mag;
			sub   <= d_mag << (n_msb - d_msb);
		end else if (!done) begin
			sub <= sub >> 1;
			if (r_mag >= sub) begin
				r_mag <= r_mag - sub;
				q_mag <= {q_mag[xlen-2:0], 1'b1};
			end else begin
				q_mag <= {q_mag[xlen-2:0], 1'b0};
			end
		end
	end

	// Quotient sign from both operands, remainder follows the dividend
	assign q_neg = signed_op && (opa[xlen-1] ^ opb[xlen-1]);
	assign r_neg = signed_op && opa[xlen-1];

	assign quotient  = ec_flag ? q_ec : (q_neg ? -q_mag : q_mag);
	assign remainder = ec_flag ? r_ec : (r_neg ? -r_mag : r_mag);

	assign busy = ec_flag ? 1'b0 : (!done && div_sel);

	a_no_busy_on_zero: assert property (
		@(posedge clk) disable iff (rst)
		(div_sel && (opb == '0)) |-> !busy
	);

	a_known_when_done: assert property (
		@(posedge clk) disable iff (rst)
		(div_sel && !busy) |-> !$isunknown({quotient, remainder})
	);

endmodule

// File: design/int_alu.sv
`timescale 1ns/1ps

module int_alu (
	input  logic [rv_isa_pkg::alu_func_w-1:0] func,
	input  logic [rv_isa_pkg::xlen-1:0]       opa,
	input  logic [rv_isa_pkg::xlen-1:0]       opb,
	output logic [rv_isa_pkg::xlen-1:0]       result
);
	import rv_isa_pkg::*;

	// Shift amount uses the low five bits of opb only
	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = opb[4:0];
	assign lt_signed   = $signed(opa) < $signed(opb);
	assign lt_unsigned = opa < opb;

	always_comb begin
		case (func)
			alu_add: begin
				result = opa + opb;
			end
			alu_sub: begin
				result = opa - opb;
			end
			alu_and: begin
				result = opa & opb;
			end
			alu_or: begin
				result = opa | opb;
			end
			alu_xor: begin
				result = opa ^ opb;
			end
			alu_sll: begin
				result = opa << shamt;
			end
			alu_srl: begin
				result = opa >> shamt;
			end
			alu_sra: begin
				result = $signed(opa) >>> shamt;
			end
			alu_slt: begin
				result = {{(xlen-1){1'b0}}, lt_signed};
			end
			alu_sltu: begin
				result = {{(xlen-1){1'b0}}, lt_unsigned};
			end
			// Division codes are handled by the divider
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: design/ex_pkg.sv
package ex_pkg;

	// Width of the tag carried from issue to result
	localparam int tag_w = 4;

	// Result register value after reset
	localparam logic [rv_isa_pkg::xlen-1:0] result_rst = '0;

	// Issue controller states
	localparam logic st_idle = 1'b0;
	localparam logic st_pend = 1'b1;

endpackage

// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

	// Data path width
	localparam int xlen = 32;

	// Width of an execute function code
	localparam int alu_func_w = 5;

	// Single-cycle ALU functions
	localparam logic [alu_func_w-1:0] alu_add  = 5'h00;
	localparam logic [alu_func_w-1:0] alu_sub  = 5'h01;
	localparam logic [alu_func_w-1:0] alu_and  = 5'h02;
	localparam logic [alu_func_w-1:0] alu_or   = 5'h03;
	localparam logic [alu_func_w-1:0] alu_xor  = 5'h04;
	localparam logic [alu_func_w-1:0] alu_sll  = 5'h05;
	localparam logic [alu_func_w-1:0] alu_srl  = 5'h06;
	localparam logic [alu_func_w-1:0] alu_sra  = 5'h07;
	localparam logic [alu_func_w-1:0] alu_slt  = 5'h08;
	localparam logic [alu_func_w-1:0] alu_sltu = 5'h09;

	// Division functions
	// Quotient codes are even and remainder codes are odd
	localparam logic [alu_func_w-1:0] alu_div  = 5'h0a;
	localparam logic [alu_func_w-1:0] alu_rem  = 5'h0b;
	localparam logic [alu_func_w-1:0] alu_divu = 5'h0c;
	localparam logic [alu_func_w-1:0] alu_remu = 5'h0d;

endpackage
